// File: panel_pkg.sv
// geometry and timing for one 64x32 HUB75 panel, scanned as two 16-row halves
// four bit planes per channel, plane n is shown for show_base_cycles << n
`default_nettype none

package panel_pkg;

    localparam int unsigned num_halves       = 2;
    localparam int unsigned half_rows        = 16;
    localparam int unsigned cols             = 64;
    localparam int unsigned planes           = 4;
    localparam int unsigned show_base_cycles = 8;   // oe cycles for plane 0

    localparam int unsigned half_words   = half_rows * cols;
    localparam int unsigned fill_cycles  = 2;       // lane read plus mask stage
    localparam int unsigned shift_cycles = fill_cycles + 2 * cols;

    typedef logic [$clog2(half_rows)-1:0]  row_t;
    typedef logic [$clog2(cols)-1:0]       col_t;
    typedef logic [$clog2(planes)-1:0]     plane_t;
    typedef logic [$clog2(half_words)-1:0] half_addr_t;  // {row, col}

    // red [11:8], green [7:4], blue [3:0]
    typedef logic [3*planes-1:0] pixel_t;

    // bit 0 red, bit 1 green, bit 2 blue
    typedef logic [2:0] rgb_t;

    typedef logic [planes-1:0] plane_mask_t;

    typedef enum logic [1:0] {
        SCAN_SHIFT,
        SCAN_LATCH,
        SCAN_SHOW
    } scan_state_t;

endpackage

`default_nettype wire

// File: cmd_pkg.sv
// command set of the byte stream, one byte per valid cycle
// every argument byte of a command must follow its opcode, nothing is framed
`default_nettype none

package cmd_pkg;

    typedef logic [7:0] cmd_byte_t;

    typedef enum logic [7:0] {
        OP_SET_PLANES  = 8'h01,  // arg: plane mask in low 4 bits
        OP_SET_RGB     = 8'h02,  // arg: channel enables in low 3 bits
        OP_WRITE_PIXEL = 8'h03   // args: row, col, pixel hi, pixel lo
    } opcode_t;

    localparam int unsigned max_args         = 4;
    localparam int unsigned args_set_planes  = 1;
    localparam int unsigned args_set_rgb     = 1;
    localparam int unsigned args_write_pixel = 4;

    typedef logic [$clog2(max_args)-1:0] arg_idx_t;

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_ARG,
        DEC_WRITE    // one cycle, pixel write on the shared bus
    } dec_state_t;

endpackage

`default_nettype wire

// File: cmd_decoder.sv
// no back-pressure, a byte is consumed in every cycle with rx_valid high
// unknown opcodes are dropped, a new opcode is taken even during a write cycle
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder
    import panel_pkg::*;
    import cmd_pkg::*;
(
    input  logic        clk_root,
    input  logic        rst_n,
    input  cmd_byte_t   rx_data,
    input  logic        rx_valid,
    output logic        wr_en,
    output logic [4:0]  wr_row,
    output col_t        wr_col,
    output pixel_t      wr_pixel,
    output plane_mask_t plane_mask,
    output rgb_t        rgb_enable
);

    dec_state_t state;
    opcode_t    opcode;
    arg_idx_t   arg_cnt;
    arg_idx_t   last_arg;
    logic       known_op;
    cmd_byte_t  args [max_args];   // argument bytes in arrival order

    // index of the final argument byte for the current opcode
    always_comb begin
        case (opcode)
            OP_WRITE_PIXEL: last_arg = arg_idx_t'(args_write_pixel - 1);
            OP_SET_RGB:     last_arg = arg_idx_t'(args_set_rgb - 1);
            default:        last_arg = arg_idx_t'(args_set_planes - 1);
        endcase
    end

    always_comb begin
        case (rx_data)
            OP_SET_PLANES, OP_SET_RGB, OP_WRITE_PIXEL: known_op = 1'b1;
            default:                                   known_op = 1'b0;
        endcase
    end

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state      <= DEC_IDLE;
            opcode     <= OP_SET_PLANES;
            arg_cnt    <= '0;
            plane_mask <= '1;   // all planes and channels lit
            rgb_enable <= '1;
        end else begin
            case (state)
                DEC_ARG: begin
                    if (rx_valid) begin
                        if (arg_cnt == last_arg) begin
                            arg_cnt <= '0;
                            state   <= DEC_IDLE;
                            case (opcode)
                                OP_SET_PLANES: plane_mask <= rx_data[3:0];
                                OP_SET_RGB:    rgb_enable <= rx_data[2:0];
                                default:       state      <= DEC_WRITE;
                            endcase
                        end else begin
                            arg_cnt <= arg_cnt + 1'b1;
                        end
                    end
                end
                default: begin   // idle or write cycle, look for an opcode
                    state <= DEC_IDLE;
                    if (rx_valid && known_op) begin
                        opcode  <= opcode_t'(rx_data);
                        arg_cnt <= '0;
                        state   <= DEC_ARG;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_root) begin
        if (state == DEC_ARG && rx_valid) begin
            args[arg_cnt] <= rx_data;
        end
    end

    // write bus straight from the held argument bytes
    assign wr_en    = (state == DEC_WRITE);
    assign wr_row   = args[0][4:0];   // bit 4 picks the half
    assign wr_col   = args[1][5:0];
    assign wr_pixel = {args[2][3:0], args[3]};

    a_single_write: assert property (
        @(posedge clk_root) disable iff (!rst_n)
        wr_en |=> !wr_en
    );

endmodule

`default_nettype wire

// File: subpanel_lane.sv
// frame buffer for one half, read to lane_rgb takes exactly two cycles
// RAM contents are undefined until written
`timescale 1ns/1ps
`default_nettype none

module subpanel_lane
    import panel_pkg::*;
#(
    parameter int unsigned half_index = 0   // matched against wr_row[4]
) (
    input  logic        clk_root,
    input  logic        rst_n,
    input  logic        wr_en,
    input  logic [4:0]  wr_row,
    input  col_t        wr_col,
    input  pixel_t      wr_pixel,
    input  plane_mask_t plane_mask,
    input  rgb_t        rgb_enable,
    input  row_t        rd_row,
    input  col_t        rd_col,
    input  plane_t      rd_plane,
    output rgb_t        lane_rgb
);

    pixel_t     mem [half_words];
    pixel_t     ram_q;
    plane_t     plane_q;    // plane travelling with the read
    half_addr_t wr_addr;
    half_addr_t rd_addr;
    logic       wr_hit;
    rgb_t       masked;

    assign wr_hit  = wr_en && (wr_row[4] == 1'(half_index));
    assign wr_addr = {wr_row[3:0], wr_col};
    assign rd_addr = {rd_row, rd_col};

    always_ff @(posedge clk_root) begin
        if (wr_hit) begin
            mem[wr_addr] <= wr_pixel;
        end
        ram_q   <= mem[rd_addr];
        plane_q <= rd_plane;
    end

    // red sits in the top nibble, so channel ch reads nibble 2 - ch
    always_comb begin
        for (int ch = 0; ch < 3; ch++) begin
            masked[ch] = ram_q[(2 - ch) * planes + plane_q]
                       & plane_mask[plane_q]
                       & rgb_enable[ch];
        end
    end

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            lane_rgb <= '0;
        end else begin
            lane_rgb <= masked;
        end
    end

    a_clean_pixel: assert property (
        @(posedge clk_root) disable iff (!rst_n)
        wr_en |-> !$isunknown(wr_pixel)
    );

endmodule

`default_nettype wire

// File: scan_engine.sv
// output_enable is active high, invert on the board if the panel needs it
// rgb outputs are unknown until the first column has been shifted
`timescale 1ns/1ps
`default_nettype none

module scan_engine
    import panel_pkg::*;
(
    input  logic                  clk_root,
    input  logic                  rst_n,
    input  rgb_t [num_halves-1:0] lane_rgb,
    output row_t                  rd_row,
    output col_t                  rd_col,
    output plane_t                rd_plane,
    output rgb_t                  rgb_top,
    output rgb_t                  rgb_bottom,
    output row_t                  row_addr,
    output logic                  pixel_clk,
    output logic                  row_latch,
    output logic                  output_enable
);

    scan_state_t state;
    scan_state_t state_next;
    logic [7:0]  tick;          // cycle count within the current state
    row_t        row_cnt;       // line being fetched and shifted
    plane_t      plane_cnt;
    plane_t      show_plane;    // plane of the line on display
    logic [7:0]  show_len;
    logic [6:0]  fetch_pos;
    logic        shift_done;
    logic        show_done;
    logic        load_rgb;

    assign show_len   = 8'(show_base_cycles) << show_plane;
    assign shift_done = (tick == 8'(shift_cycles - 1));
    assign show_done  = (tick == show_len - 8'd1);

    // column c is captured at odd tick 2c+1, clocked in at tick 2c+3
    assign load_rgb = (state == SCAN_SHIFT) && tick[0] && (tick < 8'(2 * cols));

    // fetch runs a column ahead of the output, so two reads stay in flight.
    // between shifts the address rests on column 0 of the next line
    assign fetch_pos = tick[6:0] + 7'd1;
    assign rd_col    = (state == SCAN_SHIFT && tick < 8'(2 * cols - 1)) ? fetch_pos[6:1] : '0;
    assign rd_row    = row_cnt;
    assign rd_plane  = plane_cnt;

    always_comb begin
        state_next = state;
        case (state)
            SCAN_SHIFT: begin
                if (shift_done) begin
                    state_next = SCAN_LATCH;
                end
            end
            SCAN_LATCH: state_next = SCAN_SHOW;   // single cycle pulse
            default: begin
                if (show_done) begin
                    state_next = SCAN_SHIFT;
                end
            end
        endcase
    end

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state         <= SCAN_SHIFT;
            tick          <= '0;
            row_cnt       <= '0;
            plane_cnt     <= '0;
            show_plane    <= '0;
            row_addr      <= '0;
            pixel_clk     <= 1'b0;
            row_latch     <= 1'b0;
            output_enable <= 1'b0;
        end else begin
            state <= state_next;
            tick  <= (state_next == state) ? tick + 8'd1 : '0;

            // high on odd ticks once the pipeline has filled
            pixel_clk     <= (state == SCAN_SHIFT) && !tick[0] && (tick >= 8'(fill_cycles));
            row_latch     <= (state_next == SCAN_LATCH);
            output_enable <= (state_next == SCAN_SHOW);

            if (state == SCAN_SHIFT && shift_done) begin
                row_addr   <= row_cnt;      // new row shows with the latch
                show_plane <= plane_cnt;
                plane_cnt  <= plane_cnt + 1'b1;
                if (plane_cnt == plane_t'(planes - 1)) begin
                    row_cnt <= row_cnt + 1'b1;   // planes first, then rows
                end
            end
        end
    end

    always_ff @(posedge clk_root) begin
        if (load_rgb) begin
            rgb_top    <= lane_rgb[0];
            rgb_bottom <= lane_rgb[1];
        end
    end

    a_latch_dark: assert property (
        @(posedge clk_root) disable iff (!rst_n)
        !(row_latch && output_enable)
    );

    a_clk_in_shift: assert property (
        @(posedge clk_root) disable iff (!rst_n)
        (state != SCAN_SHIFT) |-> !pixel_clk
    );

endmodule

`default_nettype wire

// File: led_matrix_top.sv
// HUB75 driver for a 64x32 panel, everything runs on clk_root
// bytes arrive already received, one per rx_valid cycle
`timescale 1ns/1ps
`default_nettype none

module led_matrix_top
    import panel_pkg::*;
    import cmd_pkg::*;
(
    input  logic      clk_root,
    input  logic      rst_n,
    input  cmd_byte_t rx_data,
    input  logic      rx_valid,
    output rgb_t      rgb_top,
    output rgb_t      rgb_bottom,
    output row_t      row_addr,
    output logic      pixel_clk,
    output logic      row_latch,
    output logic      output_enable
);

    logic                  wr_en;
    logic [4:0]            wr_row;
    col_t                  wr_col;
    pixel_t                wr_pixel;
    plane_mask_t           plane_mask;
    rgb_t                  rgb_enable;
    row_t                  rd_row;
    col_t                  rd_col;
    plane_t                rd_plane;
    rgb_t [num_halves-1:0] lane_rgb;   // index 0 is the top half

    cmd_decoder u_decoder (
        .clk_root   (clk_root),
        .rst_n      (rst_n),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .wr_en      (wr_en),
        .wr_row     (wr_row),
        .wr_col     (wr_col),
        .wr_pixel   (wr_pixel),
        .plane_mask (plane_mask),
        .rgb_enable (rgb_enable)
    );

    for (genvar h = 0; h < num_halves; h++) begin : g_lane
        subpanel_lane #(
            .half_index (h)
        ) u_lane (
            .clk_root   (clk_root),
            .rst_n      (rst_n),
            .wr_en      (wr_en),
            .wr_row     (wr_row),
            .wr_col     (wr_col),
            .wr_pixel   (wr_pixel),
            .plane_mask (plane_mask),
            .rgb_enable (rgb_enable),
            .rd_row     (rd_row),
            .rd_col     (rd_col),
            .rd_plane   (rd_plane),
            .lane_rgb   (lane_rgb[h])
        );
    end

    scan_engine u_scan (
        .clk_root      (clk_root),
        .rst_n         (rst_n),
        .lane_rgb      (lane_rgb),
        .rd_row        (rd_row),
        .rd_col        (rd_col),
        .rd_plane      (rd_plane),
        .rgb_top       (rgb_top),
        .rgb_bottom    (rgb_bottom),
        .row_addr      (row_addr),
        .pixel_clk     (pixel_clk),
        .row_latch     (row_latch),
        .output_enable (output_enable)
    );

endmodule

`default_nettype wire

// File: tb_led_matrix.sv
// stimulus and expected values come from led_matrix_tests.txt in the project root
// only pixels written since reset are compared because unwritten RAM reads as unknown
`timescale 1ns/1ps
`default_nettype none

module tb_led_matrix
    import panel_pkg::*;
    import cmd_pkg::*;
();

    localparam int frame_timeout = 50000;   // one frame is about 10k cycles

    logic      clk_root;
    logic      rst_n;
    cmd_byte_t rx_data;
    logic      rx_valid;
    rgb_t      rgb_top;
    rgb_t      rgb_bottom;
    row_t      row_addr;
    logic      pixel_clk;
    logic      row_latch;
    logic      output_enable;

    pixel_t      shadow  [2*half_rows][cols];
    bit          written [2*half_rows][cols];
    plane_mask_t exp_mask;
    rgb_t        exp_rgb;
    logic [7:0]  cur_op;
    logic [7:0]  arg_buf [max_args];
    int          args_needed;   // 0 while waiting for an opcode
    int          args_got;
    logic [31:0] rng_state;

    rgb_t line_top [cols];      // last shifted line
    rgb_t line_bot [cols];
    int   col_idx;
    int   oe_cnt;
    int   last_row;
    int   exp_row;
    int   exp_plane;
    logic prev_pclk;
    logic prev_oe;
    int   frame_req;            // 1 skips a frame start and 2 arms the compare
    bit   compare_on;
    int   lines_left;
    int   frames_done;
    int   check_count;
    int   mismatch_count;
    int   fail_count;
    bit   aborted;

    led_matrix_top dut (
        .clk_root      (clk_root),
        .rst_n         (rst_n),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .rgb_top       (rgb_top),
        .rgb_bottom    (rgb_bottom),
        .row_addr      (row_addr),
        .pixel_clk     (pixel_clk),
        .row_latch     (row_latch),
        .output_enable (output_enable)
    );

    initial begin
        clk_root = 1'b0;
        forever #2 clk_root = ~clk_root;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // lit channels of a pixel in one plane under the current enables
    function automatic rgb_t expected_rgb(input pixel_t p, input int plane);
        rgb_t       r;
        logic [3:0] nib;
        for (int ch = 0; ch < 3; ch++) begin
            case (ch)
                0:       nib = p[11:8];   // red
                1:       nib = p[7:4];
                default: nib = p[3:0];
            endcase
            r[ch] = nib[plane] & exp_mask[plane] & exp_rgb[ch];
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic end_run();
        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_count, mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic mirror_byte(input logic [7:0] b);
        if (args_needed == 0) begin
            cur_op   = b;
            args_got = 0;
            case (b)
                OP_SET_PLANES:  args_needed = args_set_planes;
                OP_SET_RGB:     args_needed = args_set_rgb;
                OP_WRITE_PIXEL: args_needed = args_write_pixel;
                default:        args_needed = 0;   // dropped
            endcase
        end else begin
            arg_buf[args_got] = b;
            args_got++;
            if (args_got == args_needed) begin
                args_needed = 0;
                if (cur_op == OP_SET_PLANES) begin
                    exp_mask = arg_buf[0][3:0];
                end else if (cur_op == OP_SET_RGB) begin
                    exp_rgb = arg_buf[0][2:0];
                end else begin
                    shadow[arg_buf[0][4:0]][arg_buf[1][5:0]]  = {arg_buf[2][3:0], arg_buf[3]};
                    written[arg_buf[0][4:0]][arg_buf[1][5:0]] = 1'b1;
                end
            end
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(posedge clk_root);
        #1;
        rx_data  = b;
        rx_valid = 1'b1;
        mirror_byte(b);
    endtask

    task automatic send_random(input int count);
        logic [31:0] x;
        for (int i = 0; i < count; i++) begin
            rng_state = xorshift(rng_state);
            x = rng_state;
            send_byte(OP_WRITE_PIXEL);
            send_byte({3'b000, x[4:0]});
            send_byte({2'b00, x[10:5]});
            send_byte(x[23:16]);   // upper nibble is junk
            send_byte(x[31:24]);
        end
    endtask

    task automatic compare_frame();
        int start;
        int waited;
        @(posedge clk_root);
        #1;
        rx_valid  = 1'b0;
        start     = frames_done;
        frame_req = 1;
        waited    = 0;
        while (frames_done == start && waited < frame_timeout) begin
            @(posedge clk_root);
            waited++;
        end
        if (frames_done == start) begin
            $display("timeout at %0t ns waiting for a full frame to be scanned", $time);
            fail_count++;
            aborted = 1'b1;
        end
    endtask

    task automatic latch_line();
        check_value("pixel_clk pulses", 32'(col_idx), 32'(cols));
        check_value("row_addr", 32'(row_addr), 32'(exp_row));
        if (row_addr == 0 && last_row == half_rows - 1) begin   // frame start
            if (frame_req == 2) begin
                compare_on = 1'b1;
                lines_left = half_rows * planes;
                frame_req  = 0;
            end else if (frame_req == 1) begin
                frame_req = 2;
            end
        end
        last_row = row_addr;
        col_idx  = 0;
        oe_cnt   = 0;
    endtask

    task automatic finish_line();
        int    plane;
        int    r;
        rgb_t  got;
        string name;
        plane = 0;
        while (plane < planes - 1 && (show_base_cycles << plane) < oe_cnt) begin
            plane++;
        end
        check_value("output_enable cycles", 32'(oe_cnt), show_base_cycles << exp_plane);
        if (compare_on) begin
            for (int c = 0; c < cols; c++) begin
                for (int h = 0; h < num_halves; h++) begin
                    r    = last_row + h * half_rows;
                    got  = (h == 0) ? line_top[c] : line_bot[c];
                    name = $sformatf("%s row %0d col %0d plane %0d",
                                     (h == 0) ? "rgb_top" : "rgb_bottom", r, c, plane);
                    if (written[r][c]) begin
                        check_value(name, 32'(got), 32'(expected_rgb(shadow[r][c], plane)));
                    end
                end
            end
            lines_left--;
            if (lines_left == 0) begin
                compare_on = 1'b0;
                frames_done++;
            end
        end
        exp_plane = (exp_plane + 1) % planes;   // planes step before rows
        if (exp_plane == 0) begin
            exp_row = (exp_row + 1) % half_rows;
        end
    endtask

    // panel outputs are settled at the falling edge
    always @(negedge clk_root) begin
        if (rst_n) begin
            if (pixel_clk && !prev_pclk) begin
                if (col_idx < cols) begin
                    line_top[col_idx] = rgb_top;
                    line_bot[col_idx] = rgb_bottom;
                end
                col_idx++;
            end
            if (row_latch) begin
                latch_line();
            end
            if (output_enable) begin
                oe_cnt++;
            end
            if (prev_oe && !output_enable) begin
                finish_line();
            end
            prev_pclk = pixel_clk;
            prev_oe   = output_enable;
        end
    end

    initial begin
        int               fd;
        int               items;
        int               count;
        string            word;
        logic [7:0]       b;
        logic [8*128-1:0] skip_buf;
        rst_n = 1'b0;
        rx_valid = 1'b0;
        rx_data = '0;
        exp_mask = '1;
        exp_rgb = '1;
        args_needed = 0;
        args_got = 0;
        rng_state = 32'h97a3_c823;
        col_idx = 0;
        oe_cnt = 0;
        last_row = 0;
        exp_row = 0;
        exp_plane = 0;
        prev_pclk = 1'b0;
        prev_oe = 1'b0;
        frame_req = 0;
        compare_on = 1'b0;
        lines_left = 0;
        frames_done = 0;
        check_count = 0;
        mismatch_count = 0;
        fail_count = 0;
        aborted = 1'b0;
        repeat (10) @(posedge clk_root);
        #1;
        rst_n = 1'b1;
        fd = $fopen("led_matrix_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open led_matrix_tests.txt");
            fail_count++;
        end else begin
            while (!aborted && $fscanf(fd, "%s", word) == 1) begin
                if (word.getc(0) == "#") begin
                    items = $fgets(skip_buf, fd);   // rest of a comment line
                end else if (word == "check") begin
                    compare_frame();
                end else if (word == "rand") begin
                    items = $fscanf(fd, "%d", count);
                    send_random(count);
                end else begin
                    items = $sscanf(word, "%h", b);
                    if (items == 1) begin
                        send_byte(b);
                    end else begin
                        $display("unreadable token %s in the tests file", word);
                        fail_count++;
                    end
                end
            end
            $fclose(fd);
        end
        end_run();
    end

endmodule

`default_nettype wire

// File: led_matrix_tests.txt
# tokens: a hex byte is sent with rx_valid high, check compares one full frame,
# rand N sends N pixel writes with xorshift row, column and value
check
03
05
0a
0f
c6
03
1b
3e
f9
2d
rand 16
check
01
05
check
02
06
check
02
05
check
02
07
7e
ff
01
0f
7e
rand 16
check

// File: build.f
panel_pkg.sv
cmd_pkg.sv
cmd_decoder.sv
subpanel_lane.sv
scan_engine.sv
led_matrix_top.sv
tb_led_matrix.sv

// File: Bender.yml
package:
  name: led_matrix

sources:
  - panel_pkg.sv
  - cmd_pkg.sv
  - cmd_decoder.sv
  - subpanel_lane.sv
  - scan_engine.sv
  - led_matrix_top.sv
  - target: test
    files:
      - tb_led_matrix.sv
